/* rtl/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

  // Number of entries held by the FIFO
  // Power of two, so both pointers wrap without extra logic
  localparam int fifo_depth = 8;

  // Bits carried by one entry
  localparam int fifo_width = 16;

  // Address bits for one storage slot
  localparam int fifo_ptr_width = $clog2(fifo_depth);

  // Count bits, wide enough for 0 through fifo_depth inclusive
  localparam int fifo_count_width = $clog2(fifo_depth + 1);

  // One stored entry
  typedef logic [fifo_width-1:0] fifo_data_t;

  // Storage address, used for both write and read pointers
  typedef logic [fifo_ptr_width-1:0] fifo_ptr_t;

  // Item or slot count
  typedef logic [fifo_count_width-1:0] fifo_count_t;

  // Single write into storage
  typedef struct packed {
    logic       en;
    fifo_ptr_t  addr;
    fifo_data_t data;
  } fifo_wr_t;

  // Status flags, used for both the current and the next-cycle view
  typedef struct packed {
    logic        full;
    logic        empty;
    fifo_count_t items;
    fifo_count_t slots;
  } fifo_status_t;

  // Status of an empty FIFO, loaded on reset
  localparam fifo_status_t fifo_status_init = '{
    full:  1'b0,
    empty: 1'b1,
    items: '0,
    slots: fifo_count_t'(fifo_depth)
  };

endpackage

`default_nettype wire

/* rtl/fifo_push_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_push_ctrl
  import fifo_pkg::*;
(
  input  wire        clk,
  input  wire        rst,

  // Producer side
  input  logic       push_valid,
  input  fifo_data_t push_data,
  output logic       push_ready,

  // Current full flag from the occupancy stage
  input  logic       full,

  // Transfer strobe toward the occupancy stage
  output logic       push_fire,

  // Write into storage
  output fifo_wr_t   wr
);

  // Next slot to be written
  fifo_ptr_t wr_ptr;

  // Room available whenever the FIFO is not full
  // No bypass, so a pop in this cycle does not free a slot for this push
  assign push_ready = ~full;

  // Transfer happens when both sides agree
  assign push_fire = push_valid & push_ready;

  // Write struct built straight from the pointer and the incoming entry
  // Enable follows the transfer, so a stalled push never writes
  assign wr.en   = push_fire;
  assign wr.addr = wr_ptr;
  assign wr.data = push_data;

  // Write pointer
  // Advances one slot per push transfer and wraps at the depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_fire) begin
      wr_ptr <= wr_ptr + fifo_ptr_t'(1);
    end
  end

endmodule

`default_nettype wire

/* rtl/fifo_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_mem
  import fifo_pkg::*;
(
  input  wire        clk,

  // Write port from the push stage
  input  fifo_wr_t   wr,

  // Read port toward the pop stage
  input  fifo_ptr_t  rd_addr,
  output fifo_data_t rd_data
);

  // Flip-flop storage, one register per entry
  fifo_data_t mem [fifo_depth];

  // Write port
  // Entry lands at the edge of the push transfer
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read port
  // Combinational, so the head entry shows as soon as the read pointer moves
  // A slot written at edge N is readable right after N
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* rtl/fifo_pop_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_pop_ctrl
  import fifo_pkg::*;
(
  input  wire        clk,
  input  wire        rst,

  // Current empty flag from the occupancy stage
  input  logic       empty,

  // Consumer side
  input  logic       pop_ready,
  output logic       pop_valid,
  output fifo_data_t pop_data,

  // Storage read port
  input  fifo_data_t rd_data,
  output fifo_ptr_t  rd_addr,

  // Transfer strobe toward the occupancy stage
  output logic       pop_fire
);

  // Slot holding the head entry
  fifo_ptr_t rd_ptr;

  // Head entry is valid whenever something is stored
  // Flag is registered, so pop_valid holds until the transfer
  assign pop_valid = ~empty;

  // Transfer happens when both sides agree
  assign pop_fire = pop_valid & pop_ready;

  // Storage is always read at the head
  assign rd_addr = rd_ptr;

  // Head entry straight from storage, qualified by pop_valid
  assign pop_data = rd_data;

  // Read pointer
  // Advances one slot per pop transfer, the next entry shows right after
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop_fire) begin
      rd_ptr <= rd_ptr + fifo_ptr_t'(1);
    end
  end

endmodule

`default_nettype wire

/* rtl/fifo_occupancy.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_occupancy
  import fifo_pkg::*;
(
  input  wire          clk,
  input  wire          rst,

  // Transfer strobes from the push and pop stages
  input  logic         push_fire,
  input  logic         pop_fire,

  // Registered status for this cycle
  output fifo_status_t status,

  // Status that takes effect at the next edge
  output fifo_status_t status_next
);

  // Item count after this cycle's transfers
  fifo_count_t items_next;

  // Free slots after this cycle's transfers
  fifo_count_t slots_next;

  // Next item count
  // Push adds one, pop removes one, both together leave it unchanged
  // Push is refused when full and pop when empty, so no wrap here
  always_comb begin
    items_next = status.items;
    if (push_fire) begin
      items_next = items_next + fifo_count_t'(1);
    end
    if (pop_fire) begin
      items_next = items_next - fifo_count_t'(1);
    end
  end

  // Slots mirror items against the depth
  assign slots_next = fifo_count_t'(fifo_depth) - items_next;

  // Next status
  // Full and empty come from the next count
  // so they line up with items and slots after the edge
  always_comb begin
    status_next.items = items_next;
    status_next.slots = slots_next;
    status_next.full  = (items_next == fifo_count_t'(fifo_depth));
    status_next.empty = (items_next == '0);
  end

  // Status register
  // Loads the whole next status at each edge
  // so the value after an edge is the status_next seen before it
  always_ff @(posedge clk) begin
    if (rst) begin
      // Empty FIFO with every slot free
      status <= fifo_status_init;
    end else begin
      status <= status_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/fifo_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_top
  import fifo_pkg::*;
(
  input  wire          clk,
  input  wire          rst,

  // Push interface
  input  logic         push_valid,
  output logic         push_ready,
  input  fifo_data_t   push_data,

  // Pop interface
  output logic         pop_valid,
  input  logic         pop_ready,
  output fifo_data_t   pop_data,

  // Status flags, current and next cycle
  output fifo_status_t status,
  output fifo_status_t status_next
);

  // Write from the push stage into storage
  fifo_wr_t   wr;

  // Transfer strobes into the occupancy stage
  logic       push_fire;
  logic       pop_fire;

  // Storage read port
  fifo_ptr_t  rd_addr;
  fifo_data_t rd_data;

  // Push stage
  // Gated by the current full flag
  fifo_push_ctrl u_push_ctrl (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .full       (status.full),
    .push_fire  (push_fire),
    .wr         (wr)
  );

  // Storage
  // Written by the push stage, read at the pop stage's head pointer
  fifo_mem u_mem (
    .clk     (clk),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Pop stage
  // Gated by the current empty flag
  fifo_pop_ctrl u_pop_ctrl (
    .clk       (clk),
    .rst       (rst),
    .empty     (status.empty),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .pop_fire  (pop_fire)
  );

  // Occupancy
  // Counts transfers and owns every status flag
  fifo_occupancy u_occupancy (
    .clk         (clk),
    .rst         (rst),
    .push_fire   (push_fire),
    .pop_fire    (pop_fire),
    .status      (status),
    .status_next (status_next)
  );

endmodule

`default_nettype wire

/* testbench/tb_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fifo
  import fifo_pkg::*;
();

  // One table row
  // Inputs for a cycle and the item count expected after its edge
  typedef struct packed {
    logic        push_valid;
    logic        pop_ready;
    fifo_count_t items;
  } row_t;

  localparam int reset_cycles = 16;
  localparam int num_rows = 50;
  // Reset and every row plus a margin
  localparam int cycle_limit = reset_cycles + num_rows + 20;

  // Stalled pushes keep their valid and data through later rows
  localparam row_t rows [num_rows] = '{
    // Fill to full with pop_ready low
    // Last pushes stall
    '{1'b1, 1'b0, 4'd1}, '{1'b1, 1'b0, 4'd2}, '{1'b1, 1'b0, 4'd3}, '{1'b1, 1'b0, 4'd4},
    '{1'b1, 1'b0, 4'd5}, '{1'b1, 1'b0, 4'd6}, '{1'b1, 1'b0, 4'd7}, '{1'b1, 1'b0, 4'd8},
    '{1'b1, 1'b0, 4'd8}, '{1'b1, 1'b0, 4'd8},
    // Hold while full
    '{1'b1, 1'b0, 4'd8}, '{1'b1, 1'b0, 4'd8}, '{1'b1, 1'b0, 4'd8}, '{1'b1, 1'b0, 4'd8},
    // Drain with push_valid low
    // Held push lands once full drops
    '{1'b0, 1'b1, 4'd7}, '{1'b0, 1'b1, 4'd7}, '{1'b0, 1'b1, 4'd6}, '{1'b0, 1'b1, 4'd5},
    '{1'b0, 1'b1, 4'd4}, '{1'b0, 1'b1, 4'd3}, '{1'b0, 1'b1, 4'd2}, '{1'b0, 1'b1, 4'd1},
    '{1'b0, 1'b1, 4'd0}, '{1'b0, 1'b1, 4'd0},
    // Up to middle occupancy
    '{1'b1, 1'b0, 4'd1}, '{1'b1, 1'b0, 4'd2}, '{1'b1, 1'b0, 4'd3}, '{1'b1, 1'b0, 4'd4},
    // Push and pop together with the count held
    '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4},
    '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4}, '{1'b1, 1'b1, 4'd4},
    // Alternating bursts ending empty
    '{1'b1, 1'b0, 4'd5}, '{1'b1, 1'b0, 4'd6}, '{1'b1, 1'b0, 4'd7},
    '{1'b0, 1'b1, 4'd6}, '{1'b0, 1'b1, 4'd5}, '{1'b0, 1'b1, 4'd4},
    '{1'b1, 1'b0, 4'd5}, '{1'b1, 1'b0, 4'd6},
    '{1'b0, 1'b1, 4'd5}, '{1'b0, 1'b1, 4'd4}, '{1'b0, 1'b1, 4'd3}, '{1'b0, 1'b1, 4'd2},
    '{1'b0, 1'b1, 4'd1}, '{1'b0, 1'b1, 4'd0}
  };

  logic         clk;
  logic         rst;
  logic         push_valid;
  logic         push_ready;
  fifo_data_t   push_data;
  logic         pop_valid;
  logic         pop_ready;
  fifo_data_t   pop_data;
  fifo_status_t status;
  fifo_status_t status_next;

  // Expected contents, head at index 0
  fifo_data_t   model_q [$];
  // status_next seen just before the last edge
  fifo_status_t prev_next = fifo_status_init;
  // Push offered but refused and still held
  logic         stalled = 1'b0;
  int           cycle_count = 0;

  fifo_top u_fifo_top (
    .clk         (clk),
    .rst         (rst),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_data   (push_data),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .pop_data    (pop_data),
    .status      (status),
    .status_next (status_next)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_count);
      $display("Regression failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // Status after an edge against the table, the queue and the earlier status_next
  task automatic check_status(input fifo_count_t exp_items);
    int size;
    size = model_q.size();
    check_value("status.items", 32'(status.items), 32'(exp_items));
    check_value("status.items (model)", 32'(status.items), 32'(size));
    check_value("status.slots", 32'(status.slots), 32'(fifo_depth - size));
    check_value("status.full", 32'(status.full), 32'(size == fifo_depth));
    check_value("status.empty", 32'(status.empty), 32'(size == 0));
    check_value("status", 32'(status), 32'(prev_next));
    // Back-pressure follows the model occupancy
    check_value("push_ready", 32'(push_ready), 32'(size != fifo_depth));
    check_value("pop_valid", 32'(pop_valid), 32'(size != 0));
  endtask

  // Transfers of the coming edge as the handshakes show them now
  task automatic take_transfers();
    logic push_fire;
    logic pop_fire;
    int   size;
    push_fire = push_valid && push_ready;
    pop_fire = pop_valid && pop_ready;
    size = model_q.size();
    if (pop_fire) begin
      check_value("pop_data", 32'(pop_data), 32'(model_q[0]));
      void'(model_q.pop_front());
    end
    // Both at once leave the count alone
    if (push_fire && pop_fire) begin
      check_value("status_next.items", 32'(status_next.items), 32'(size));
    end
    if (push_fire) begin
      model_q.push_back(push_data);
    end
    stalled = push_valid && !push_ready;
    prev_next = status_next;
  endtask

  initial begin
    void'($urandom(32'ha701));
    rst <= 1'b1;
    push_valid <= 1'b0;
    pop_ready <= 1'b0;
    push_data <= '0;

    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;

    // Empty FIFO straight out of reset
    @(negedge clk);
    check_status(fifo_count_t'(0));
    prev_next = status_next;

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      // Refused push keeps valid and data
      if (!stalled) begin
        push_valid <= rows[i].push_valid;
        push_data <= fifo_data_t'($urandom());
      end
      pop_ready <= rows[i].pop_ready;

      // Inputs and outputs settled by the falling edge
      @(negedge clk);
      if (i > 0) begin
        check_status(rows[i - 1].items);
      end else begin
        // Nothing transferred yet on the first row
        check_status(fifo_count_t'(0));
      end
      take_transfers();
    end

    // Result of the last row
    @(posedge clk);
    push_valid <= 1'b0;
    pop_ready <= 1'b0;
    @(negedge clk);
    check_status(rows[num_rows - 1].items);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/fifo_pkg.sv
rtl/fifo_push_ctrl.sv
rtl/fifo_mem.sv
rtl/fifo_pop_ctrl.sv
rtl/fifo_occupancy.sv
rtl/fifo_top.sv
testbench/tb_fifo.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_fifo -o tb_fifo
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_fifo 2>&1)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
